//--- dram_bridge_pkg.sv
// field widths of the cache-order and DRAM-order addresses
// address, channel address and read data types
`default_nettype none

package dram_bridge_pkg;

  // address fields
  localparam int bg_width_lp = 2;
  localparam int ba_width_lp = 2;
  localparam int ro_width_lp = 15;
  localparam int co_width_lp = 6;
  localparam int byte_offset_width_lp = 5;

  // bank group and bank move as one block during the reorder
  localparam int bgba_width_lp = bg_width_lp + ba_width_lp;

  // column and byte offset sit at the bottom in both orders
  localparam int low_width_lp = co_width_lp + byte_offset_width_lp;

  localparam int cache_addr_width_lp =
    bg_width_lp + ba_width_lp + ro_width_lp + co_width_lp + byte_offset_width_lp;

  // one side bit on top of the channel address
  localparam int ch_addr_width_lp = cache_addr_width_lp + 1;

  // HBM2 x128 channel word
  localparam int dram_data_width_lp = 128;

  // bg, ba, ro, co, byte offset from the top down
  typedef logic [cache_addr_width_lp-1:0] cache_addr_t;

  // ro, bg, ba, co, byte offset from the top down
  typedef logic [cache_addr_width_lp-1:0] side_addr_t;

  // side bit above a side_addr_t (0 north and 1 south)
  typedef logic [ch_addr_width_lp-1:0] ch_addr_t;

  typedef logic [dram_data_width_lp-1:0] dram_data_t;

endpackage

`default_nettype wire

//--- dram_side_if.sv
// request and read return between one side port and the arbiter
`default_nettype none

interface dram_side_if import dram_bridge_pkg::*; ();

  // valid/yumi request
  logic req_v;
  logic write_not_read;
  side_addr_t req_addr;
  logic yumi;

  // read return as a single cycle pulse
  logic rd_v;
  side_addr_t rd_addr;
  dram_data_t rd_data;

  modport side (
    output req_v, write_not_read, req_addr,
    input yumi,
    input rd_v, rd_addr, rd_data
  );

  modport arb (
    input req_v, write_not_read, req_addr,
    output yumi,
    output rd_v, rd_addr, rd_data
  );

endinterface

`default_nettype wire

//--- dram_side_port.sv
// one-entry request slot for a vcache row
// cache to DRAM address reorder and registered read return
`default_nettype none

module dram_side_port import dram_bridge_pkg::*; (
  input logic core_clk,
  input logic reset_i,

  input logic pkt_v_i,
  input logic pkt_write_not_read_i,
  input cache_addr_t pkt_addr_i,
  output logic pkt_yumi_o,

  output logic rd_v_o,
  output cache_addr_t rd_addr_o,
  output dram_data_t rd_data_o,

  dram_side_if.side side
);

  // {bg, ba, ro, low} -> {ro, bg, ba, low}
  function automatic side_addr_t to_dram_order(cache_addr_t addr);
    logic [bgba_width_lp-1:0] bgba;
    logic [ro_width_lp-1:0] ro;
    bgba = addr[cache_addr_width_lp-1 -: bgba_width_lp];
    ro = addr[low_width_lp +: ro_width_lp];
    return {ro, bgba, addr[low_width_lp-1:0]};
  endfunction

  // {ro, bg, ba, low} -> {bg, ba, ro, low}
  function automatic cache_addr_t to_cache_order(side_addr_t addr);
    logic [ro_width_lp-1:0] ro;
    logic [bgba_width_lp-1:0] bgba;
    ro = addr[cache_addr_width_lp-1 -: ro_width_lp];
    bgba = addr[low_width_lp +: bgba_width_lp];
    return {bgba, ro, addr[low_width_lp-1:0]};
  endfunction

  logic slot_v_r;
  logic slot_wnr_r;
  side_addr_t slot_addr_r;

  logic rd_v_r;
  cache_addr_t rd_addr_r;
  dram_data_t rd_data_r;

  // take a packet when the slot is free or leaves this cycle
  assign pkt_yumi_o = pkt_v_i & (~slot_v_r | side.yumi);

  always_ff @(posedge core_clk) begin
    if (reset_i) begin
      slot_v_r <= 1'b0;
    end else if (pkt_yumi_o) begin
      slot_v_r <= 1'b1;
    end else if (side.yumi) begin
      slot_v_r <= 1'b0;
    end
  end

  always_ff @(posedge core_clk) begin
    if (pkt_yumi_o) begin
      slot_wnr_r <= pkt_write_not_read_i;
      slot_addr_r <= to_dram_order(pkt_addr_i);
    end
  end

  assign side.req_v = slot_v_r;
  assign side.write_not_read = slot_wnr_r;
  assign side.req_addr = slot_addr_r;

  // read return
  always_ff @(posedge core_clk) begin
    if (reset_i) begin
      rd_v_r <= 1'b0;
    end else begin
      rd_v_r <= side.rd_v;
    end
  end

  always_ff @(posedge core_clk) begin
    if (side.rd_v) begin
      rd_addr_r <= to_cache_order(side.rd_addr);
      rd_data_r <= side.rd_data;
    end
  end

  assign rd_v_o = rd_v_r;
  assign rd_addr_o = rd_addr_r;
  assign rd_data_o = rd_data_r;

  // pending request holds until the arbiter takes it
  assert property (@(posedge core_clk) disable iff (reset_i)
    side.req_v && !side.yumi |=>
      side.req_v && $stable(side.req_addr) && $stable(side.write_not_read));

endmodule

`default_nettype wire

//--- dram_req_arbiter.sv
// round-robin arbiter of north and south onto one DRAM channel
// side bit tagging of requests and routing of read returns
`default_nettype none

module dram_req_arbiter import dram_bridge_pkg::*; (
  input logic core_clk,
  input logic reset_i,

  dram_side_if.arb north,
  dram_side_if.arb south,

  output logic dram_req_v_o,
  output logic dram_write_not_read_o,
  output ch_addr_t dram_ch_addr_o,
  input logic dram_req_yumi_i,

  input logic dram_data_v_i,
  input ch_addr_t dram_ch_addr_i,
  input dram_data_t dram_data_i
);

  logic last_south_r;
  logic hold_v_r;
  logic hold_south_r;
  logic rr_south;
  logic grant_south;
  logic ret_south;

  // on a tie the side not granted last wins
  assign rr_south = south.req_v & (~north.req_v | ~last_south_r);

  // keep the grant on a stalled request so the outputs hold
  assign grant_south = hold_v_r ? hold_south_r : rr_south;

  always_ff @(posedge core_clk) begin
    if (reset_i) begin
      last_south_r <= 1'b1;
      hold_v_r <= 1'b0;
    end else begin
      if (dram_req_v_o & dram_req_yumi_i) begin
        last_south_r <= grant_south;
      end
      hold_v_r <= dram_req_v_o & ~dram_req_yumi_i;
    end
  end

  always_ff @(posedge core_clk) begin
    hold_south_r <= grant_south;
  end

  assign dram_req_v_o = north.req_v | south.req_v;
  assign dram_write_not_read_o = grant_south ? south.write_not_read : north.write_not_read;
  assign dram_ch_addr_o = grant_south ? {1'b1, south.req_addr} : {1'b0, north.req_addr};

  assign north.yumi = dram_req_yumi_i & ~grant_south;
  assign south.yumi = dram_req_yumi_i & grant_south;

  // read return goes to the side named by the top bit
  assign ret_south = dram_ch_addr_i[ch_addr_width_lp-1];

  assign north.rd_v = dram_data_v_i & ~ret_south;
  assign north.rd_addr = dram_ch_addr_i[cache_addr_width_lp-1:0];
  assign north.rd_data = dram_data_i;

  assign south.rd_v = dram_data_v_i & ret_south;
  assign south.rd_addr = dram_ch_addr_i[cache_addr_width_lp-1:0];
  assign south.rd_data = dram_data_i;

  // yumi reaches one side at most and only a side that requests
  assert property (@(posedge core_clk) disable iff (reset_i)
    !(north.yumi && south.yumi) &&
    (!north.yumi || north.req_v) && (!south.yumi || south.req_v));

  // the channel only takes a request that is offered
  assert property (@(posedge core_clk) disable iff (reset_i)
    dram_req_yumi_i |-> dram_req_v_o);

endmodule

`default_nettype wire

//--- dram_req_bridge.sv
// DRAM request bridge top level
// north and south side ports sharing one DRAM channel through the arbiter
`default_nettype none

module dram_req_bridge import dram_bridge_pkg::*; (
  input logic core_clk,
  input logic reset_i,

  // north vcache row
  input logic north_pkt_v_i,
  input logic north_pkt_write_not_read_i,
  input cache_addr_t north_pkt_addr_i,
  output logic north_pkt_yumi_o,
  output logic north_rd_v_o,
  output cache_addr_t north_rd_addr_o,
  output dram_data_t north_rd_data_o,

  // south vcache row
  input logic south_pkt_v_i,
  input logic south_pkt_write_not_read_i,
  input cache_addr_t south_pkt_addr_i,
  output logic south_pkt_yumi_o,
  output logic south_rd_v_o,
  output cache_addr_t south_rd_addr_o,
  output dram_data_t south_rd_data_o,

  // DRAM channel
  output logic dram_req_v_o,
  output logic dram_write_not_read_o,
  output ch_addr_t dram_ch_addr_o,
  input logic dram_req_yumi_i,
  input logic dram_data_v_i,
  input ch_addr_t dram_ch_addr_i,
  input dram_data_t dram_data_i
);

  dram_side_if north_if ();
  dram_side_if south_if ();

  dram_side_port north_port (
    .core_clk(core_clk),
    .reset_i(reset_i),
    .pkt_v_i(north_pkt_v_i),
    .pkt_write_not_read_i(north_pkt_write_not_read_i),
    .pkt_addr_i(north_pkt_addr_i),
    .pkt_yumi_o(north_pkt_yumi_o),
    .rd_v_o(north_rd_v_o),
    .rd_addr_o(north_rd_addr_o),
    .rd_data_o(north_rd_data_o),
    .side(north_if.side)
  );

  dram_side_port south_port (
    .core_clk(core_clk),
    .reset_i(reset_i),
    .pkt_v_i(south_pkt_v_i),
    .pkt_write_not_read_i(south_pkt_write_not_read_i),
    .pkt_addr_i(south_pkt_addr_i),
    .pkt_yumi_o(south_pkt_yumi_o),
    .rd_v_o(south_rd_v_o),
    .rd_addr_o(south_rd_addr_o),
    .rd_data_o(south_rd_data_o),
    .side(south_if.side)
  );

  dram_req_arbiter arb (
    .core_clk(core_clk),
    .reset_i(reset_i),
    .north(north_if.arb),
    .south(south_if.arb),
    .dram_req_v_o(dram_req_v_o),
    .dram_write_not_read_o(dram_write_not_read_o),
    .dram_ch_addr_o(dram_ch_addr_o),
    .dram_req_yumi_i(dram_req_yumi_i),
    .dram_data_v_i(dram_data_v_i),
    .dram_ch_addr_i(dram_ch_addr_i),
    .dram_data_i(dram_data_i)
  );

endmodule

`default_nettype wire

//--- dram_req_bridge_tb.sv
// testbench for the DRAM request bridge
// random traffic on both sides checked against a queue model,
// grant model and read return model
`default_nettype none

module dram_req_bridge_tb import dram_bridge_pkg::*; ();

  localparam int reset_cycles_lp = 5;
  localparam int mixed_cycles_lp = 400;
  localparam int stall_cycles_lp = 300;
  localparam int drain_cycles_lp = 20;
  localparam int timeout_lp =
    4 * (reset_cycles_lp + 2 + mixed_cycles_lp + stall_cycles_lp + drain_cycles_lp) + 100;

  logic core_clk;
  logic reset_i;
  logic north_pkt_v_i;
  logic north_pkt_write_not_read_i;
  cache_addr_t north_pkt_addr_i;
  logic north_pkt_yumi_o;
  logic north_rd_v_o;
  cache_addr_t north_rd_addr_o;
  dram_data_t north_rd_data_o;
  logic south_pkt_v_i;
  logic south_pkt_write_not_read_i;
  cache_addr_t south_pkt_addr_i;
  logic south_pkt_yumi_o;
  logic south_rd_v_o;
  cache_addr_t south_rd_addr_o;
  dram_data_t south_rd_data_o;
  logic dram_req_v_o;
  logic dram_write_not_read_o;
  ch_addr_t dram_ch_addr_o;
  logic dram_req_yumi_i;
  logic dram_data_v_i;
  ch_addr_t dram_ch_addr_i;
  dram_data_t dram_data_i;

  // stimulus state owned by the main process
  integer seed;
  logic offer_en;
  logic [31:0] yumi_pct;
  logic north_pend;
  logic south_pend;
  int test_count;
  int test_fail_count;
  int test_start_errs;

  // model state owned by the monitor
  int err_count;
  logic north_accepted;
  logic south_accepted;
  logic [cache_addr_width_lp:0] north_q[$];
  logic [cache_addr_width_lp:0] south_q[$];
  logic last_south_m;
  logic held_m;
  logic held_wnr_m;
  ch_addr_t held_addr_m;
  logic rd_exp_v;
  logic rd_exp_south;
  cache_addr_t rd_exp_addr;
  dram_data_t rd_exp_data;

  int cycle_count;

  dram_req_bridge i_dram_req_bridge (.*);

  initial begin
    core_clk = 1'b0;
    forever #5 core_clk = ~core_clk;
  end

  // cache order is bg, ba, ro, co, offset; DRAM order is ro, bg, ba, co, offset
  function automatic side_addr_t dram_order(cache_addr_t a);
    logic [bg_width_lp-1:0] bg;
    logic [ba_width_lp-1:0] ba;
    logic [ro_width_lp-1:0] ro;
    logic [co_width_lp-1:0] co;
    logic [byte_offset_width_lp-1:0] off;
    {bg, ba, ro, co, off} = a;
    return {ro, bg, ba, co, off};
  endfunction

  function automatic cache_addr_t cache_order(side_addr_t a);
    logic [bg_width_lp-1:0] bg;
    logic [ba_width_lp-1:0] ba;
    logic [ro_width_lp-1:0] ro;
    logic [co_width_lp-1:0] co;
    logic [byte_offset_width_lp-1:0] off;
    {ro, bg, ba, co, off} = a;
    return {bg, ba, ro, co, off};
  endfunction

  task automatic report_value(input string name, input dram_data_t exp_v,
                              input dram_data_t got_v);
    $display("ERR %s expected %0h got %0h", name, exp_v, got_v);
    err_count++;
  endtask

  task automatic report_fault(input string msg);
    $display("error: %s", msg);
    err_count++;
  endtask

  task automatic drive_inputs();
    logic [31:0] rnd;
    if (north_accepted) north_pend = 1'b0;
    if (south_accepted) south_pend = 1'b0;
    rnd = $random(seed);
    if (!north_pend && offer_en && rnd[1:0] != 2'b00) begin
      north_pend = 1'b1;
      north_pkt_write_not_read_i = rnd[2];
      rnd = $random(seed);
      north_pkt_addr_i = rnd[cache_addr_width_lp-1:0];
    end
    rnd = $random(seed);
    if (!south_pend && offer_en && rnd[1:0] != 2'b00) begin
      south_pend = 1'b1;
      south_pkt_write_not_read_i = rnd[2];
      rnd = $random(seed);
      south_pkt_addr_i = rnd[cache_addr_width_lp-1:0];
    end
    north_pkt_v_i = north_pend;
    south_pkt_v_i = south_pend;
    rnd = $random(seed);
    dram_req_yumi_i = dram_req_v_o && ((rnd % 32'd100) < yumi_pct);
    rnd = $random(seed);
    dram_data_v_i = (rnd[1:0] == 2'b00);
    rnd = $random(seed);
    dram_ch_addr_i = rnd[ch_addr_width_lp-1:0];
    dram_data_i = {$random(seed), $random(seed), $random(seed), $random(seed)};
  endtask

  task automatic run_cycles(input int n);
    repeat (n) begin
      @(posedge core_clk);
      #1;
      drive_inputs();
    end
  endtask

  task automatic finish_test(input string name);
    int errs;
    errs = err_count - test_start_errs;
    test_count++;
    if (errs != 0) begin
      test_fail_count++;
      $display("test %0d %s: failed, %0d errors", test_count, name, errs);
    end else begin
      $display("test %0d %s: ok", test_count, name);
    end
    test_start_errs = err_count;
  endtask

  task automatic check_reset_state();
    assert (dram_req_v_o === 1'b0)
      else report_value("dram_req_v_o", 0, dram_data_t'(dram_req_v_o));
    assert (north_rd_v_o === 1'b0)
      else report_value("north_rd_v_o", 0, dram_data_t'(north_rd_v_o));
    assert (south_rd_v_o === 1'b0)
      else report_value("south_rd_v_o", 0, dram_data_t'(south_rd_v_o));
    north_q.delete();
    south_q.delete();
    north_accepted = 1'b0;
    south_accepted = 1'b0;
    last_south_m = 1'b1;
    held_m = 1'b0;
    rd_exp_v = 1'b0;
  endtask

  task automatic check_read_return();
    string side_name;
    logic exp_n;
    logic exp_s;
    cache_addr_t got_addr;
    dram_data_t got_data;
    exp_n = rd_exp_v & ~rd_exp_south;
    exp_s = rd_exp_v & rd_exp_south;
    assert (north_rd_v_o === exp_n)
      else report_value("north_rd_v_o", dram_data_t'(exp_n), dram_data_t'(north_rd_v_o));
    assert (south_rd_v_o === exp_s)
      else report_value("south_rd_v_o", dram_data_t'(exp_s), dram_data_t'(south_rd_v_o));
    if (rd_exp_v) begin
      side_name = rd_exp_south ? "south" : "north";
      got_addr = rd_exp_south ? south_rd_addr_o : north_rd_addr_o;
      got_data = rd_exp_south ? south_rd_data_o : north_rd_data_o;
      assert (got_addr === rd_exp_addr) else report_value({side_name, "_rd_addr_o"},
        dram_data_t'(rd_exp_addr), dram_data_t'(got_addr));
      assert (got_data === rd_exp_data)
        else report_value({side_name, "_rd_data_o"}, rd_exp_data, got_data);
    end
    rd_exp_v = dram_data_v_i;
    rd_exp_south = dram_ch_addr_i[ch_addr_width_lp-1];
    rd_exp_addr = cache_order(dram_ch_addr_i[cache_addr_width_lp-1:0]);
    rd_exp_data = dram_data_i;
  endtask

  task automatic check_requests();
    logic n_busy;
    logic s_busy;
    logic n_leave;
    logic s_leave;
    logic side;
    logic exp_yumi;
    logic [cache_addr_width_lp:0] front;
    ch_addr_t exp_addr;
    n_busy = (north_q.size() != 0);
    s_busy = (south_q.size() != 0);
    n_leave = 1'b0;
    s_leave = 1'b0;
    // a stalled request holds its outputs
    if (held_m) begin
      assert (dram_ch_addr_o === held_addr_m) else report_value("dram_ch_addr_o",
        dram_data_t'(held_addr_m), dram_data_t'(dram_ch_addr_o));
      assert (dram_write_not_read_o === held_wnr_m) else report_value("dram_write_not_read_o",
        dram_data_t'(held_wnr_m), dram_data_t'(dram_write_not_read_o));
    end
    assert (dram_req_v_o === (n_busy | s_busy)) else report_value("dram_req_v_o",
      dram_data_t'(n_busy | s_busy), dram_data_t'(dram_req_v_o));
    if (dram_req_v_o && dram_req_yumi_i) begin
      side = dram_ch_addr_o[ch_addr_width_lp-1];
      if (side ? !s_busy : !n_busy) begin
        report_fault("request sent for a side that has no queued packet");
      end else begin
        if (side) front = south_q.pop_front();
        else front = north_q.pop_front();
        exp_addr = {side, dram_order(front[cache_addr_width_lp-1:0])};
        assert (dram_ch_addr_o === exp_addr) else report_value("dram_ch_addr_o",
          dram_data_t'(exp_addr), dram_data_t'(dram_ch_addr_o));
        assert (dram_write_not_read_o === front[cache_addr_width_lp])
          else report_value("dram_write_not_read_o", dram_data_t'(front[cache_addr_width_lp]),
            dram_data_t'(dram_write_not_read_o));
        if (n_busy && s_busy && !held_m) begin
          assert (side === !last_south_m) else report_value("grant_side",
            dram_data_t'(!last_south_m), dram_data_t'(side));
        end
        last_south_m = side;
        n_leave = ~side;
        s_leave = side;
      end
    end
    held_m = dram_req_v_o && !dram_req_yumi_i;
    held_wnr_m = dram_write_not_read_o;
    held_addr_m = dram_ch_addr_o;
    exp_yumi = north_pkt_v_i & (~n_busy | n_leave);
    assert (north_pkt_yumi_o === exp_yumi) else report_value("north_pkt_yumi_o",
      dram_data_t'(exp_yumi), dram_data_t'(north_pkt_yumi_o));
    exp_yumi = south_pkt_v_i & (~s_busy | s_leave);
    assert (south_pkt_yumi_o === exp_yumi) else report_value("south_pkt_yumi_o",
      dram_data_t'(exp_yumi), dram_data_t'(south_pkt_yumi_o));
    north_accepted = north_pkt_v_i && north_pkt_yumi_o;
    south_accepted = south_pkt_v_i && south_pkt_yumi_o;
    if (north_accepted) north_q.push_back({north_pkt_write_not_read_i, north_pkt_addr_i});
    if (south_accepted) south_q.push_back({south_pkt_write_not_read_i, south_pkt_addr_i});
  endtask

  // outputs are settled by the falling edge
  always @(negedge core_clk) begin
    if (reset_i) begin
      check_reset_state();
    end else begin
      check_read_return();
      check_requests();
    end
  end

  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count < timeout_lp) begin
      @(posedge core_clk);
      cycle_count++;
    end
    $display("timeout: run did not finish within %0d cycles", timeout_lp);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin : main
    seed = 74124;
    reset_i = 1'b1;
    north_pkt_v_i = 1'b0;
    north_pkt_write_not_read_i = 1'b0;
    north_pkt_addr_i = '0;
    south_pkt_v_i = 1'b0;
    south_pkt_write_not_read_i = 1'b0;
    south_pkt_addr_i = '0;
    dram_req_yumi_i = 1'b0;
    dram_data_v_i = 1'b0;
    dram_ch_addr_i = '0;
    dram_data_i = '0;
    offer_en = 1'b0;
    yumi_pct = 32'd0;
    north_pend = 1'b0;
    south_pend = 1'b0;
    test_count = 0;
    test_fail_count = 0;
    test_start_errs = 0;
    repeat (reset_cycles_lp) @(posedge core_clk);
    #1;
    reset_i = 1'b0;
    run_cycles(2);
    finish_test("reset state");
    offer_en = 1'b1;
    yumi_pct = 32'd70;
    run_cycles(mixed_cycles_lp);
    finish_test("mixed traffic");
    yumi_pct = 32'd15;
    run_cycles(stall_cycles_lp);
    finish_test("back-pressure");
    // no new packets so every queued request must leave
    offer_en = 1'b0;
    yumi_pct = 32'd100;
    while (north_pend || south_pend || north_q.size() != 0 || south_q.size() != 0) begin
      run_cycles(1);
    end
    run_cycles(2);
    finish_test("drain");
    $display("tests %0d, failed %0d, errors %0d", test_count, test_fail_count, err_count);
    if (err_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- dram_req_bridge.f
dram_bridge_pkg.sv
dram_side_if.sv
dram_side_port.sv
dram_req_arbiter.sv
dram_req_bridge.sv
dram_req_bridge_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile the testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Mdir obj_dir -o dram_req_bridge_sim \
  --top-module dram_req_bridge_tb -f dram_req_bridge.f
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

out=$(./obj_dir/dram_req_bridge_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q "^Simulation finished: PASS$"; then
  exit 0
fi
echo "pass message not found"
exit 1
